// File: include/lc3b_cache_consts.svh
`ifndef LC3B_CACHE_CONSTS_SVH
`define LC3B_CACHE_CONSTS_SVH

// Tag, index and byte offset of a 16-bit byte address
`define CACHE_TAG_W 9
`define CACHE_INDEX_W 3
`define CACHE_OFFSET_W 4

// Geometry
`define CACHE_SETS 8
`define CACHE_LINE_W 128
`define CACHE_WORDS 8

`endif

// File: verilog/lc3b_types.sv
`default_nettype none

`include "lc3b_cache_consts.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [`CACHE_LINE_W-1:0] lc3b_c_line;
    typedef logic [`CACHE_TAG_W-1:0] lc3b_c_tag;
    typedef logic [`CACHE_INDEX_W-1:0] lc3b_c_index;
    typedef logic [`CACHE_OFFSET_W-2:0] lc3b_c_offset;  // Word within line

    // CPU request held until cpu_resp
    typedef struct packed {
        lc3b_word address;
        lc3b_word wdata;
        logic [1:0] byte_en;                            // [1] high byte, [0] low byte
        logic read;
        logic write;
    } cpu_req_t;

    // Line transfer towards memory held until mem_resp
    typedef struct packed {
        lc3b_word address;                              // Line aligned
        lc3b_c_line wdata;
        logic read;
        logic write;
    } mem_req_t;

    typedef enum logic [1:0] {
        check,
        write_back,
        allocate
    } cache_state_e;

endpackage : lc3b_types

`default_nettype wire

// File: verilog/cache_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_cache_consts.svh"

module cache_array #(
    parameter int width = 1
) (
    input logic clk,
    input logic rst,
    input logic write,
    input lc3b_types::lc3b_c_index index,
    input logic [width-1:0] datain,
    output logic [width-1:0] dataout
);

    logic [width-1:0] data [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                data[i] <= '0;
            end
        end else if (write) begin
            data[index] <= datain;
        end
    end

    // Read path has no register
    assign dataout = data[index];

endmodule : cache_array

`default_nettype wire

// File: verilog/cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_cache_consts.svh"

module cache_datapath (
    input logic clk,
    input logic rst,
    input lc3b_types::cpu_req_t cpu_req,
    input logic hit_enable,
    input logic reload,
    input logic write_back,
    input lc3b_types::lc3b_c_line mem_rdata,
    output logic hit,
    output logic victim_dirty,
    output lc3b_types::lc3b_word cpu_rdata,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_c_line mem_wdata
);

    lc3b_types::lc3b_c_tag cpu_tag;
    lc3b_types::lc3b_c_index cpu_index;
    lc3b_types::lc3b_c_offset word_off;

    logic [1:0] match;
    logic [1:0] victim_sel;
    logic [1:0] fill_we;
    logic [1:0] hit_we;
    logic [1:0] valid_out;
    logic [1:0] dirty_out;
    lc3b_types::lc3b_c_tag tag_out [2];
    lc3b_types::lc3b_c_line data_out [2];

    logic lru_out;                                      // Names the victim way
    lc3b_types::lc3b_c_tag victim_tag;
    lc3b_types::lc3b_c_line hit_line;
    lc3b_types::lc3b_c_line merged_line;
    lc3b_types::lc3b_c_line line_in;
    lc3b_types::lc3b_word old_word;
    lc3b_types::lc3b_word new_word;

    assign cpu_tag = cpu_req.address[15 -: `CACHE_TAG_W];
    assign cpu_index = cpu_req.address[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_off = cpu_req.address[`CACHE_OFFSET_W-1:1];

    assign victim_sel = {lru_out, ~lru_out};

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign match[w] = valid_out[w] & (tag_out[w] == cpu_tag);
        assign fill_we[w] = reload & victim_sel[w];
        assign hit_we[w] = hit_enable & cpu_req.write & match[w];

        cache_array #(.width(1)) valid_arr (
            .clk,
            .rst,
            .write(fill_we[w]),
            .index(cpu_index),
            .datain(1'b1),
            .dataout(valid_out[w])
        );

        cache_array #(.width(`CACHE_TAG_W)) tag_arr (
            .clk,
            .rst,
            .write(fill_we[w]),
            .index(cpu_index),
            .datain(cpu_tag),
            .dataout(tag_out[w])
        );

        // A fill clears dirty, a write hit sets it
        cache_array #(.width(1)) dirty_arr (
            .clk,
            .rst,
            .write(fill_we[w] | hit_we[w]),
            .index(cpu_index),
            .datain(~reload),
            .dataout(dirty_out[w])
        );

        cache_array #(.width(`CACHE_LINE_W)) data_arr (
            .clk,
            .rst,
            .write(fill_we[w] | hit_we[w]),
            .index(cpu_index),
            .datain(line_in),
            .dataout(data_out[w])
        );
    end

    // After a hit on way 0 the victim becomes way 1 and the other way round
    cache_array #(.width(1)) lru_arr (
        .clk,
        .rst,
        .write(hit_enable & hit),
        .index(cpu_index),
        .datain(match[0]),
        .dataout(lru_out)
    );

    assign hit = |match;
    assign hit_line = match[1] ? data_out[1] : data_out[0];

    always_comb begin
        old_word = hit_line[word_off*16 +: 16];
        new_word[15:8] = cpu_req.byte_en[1] ? cpu_req.wdata[15:8] : old_word[15:8];
        new_word[7:0] = cpu_req.byte_en[0] ? cpu_req.wdata[7:0] : old_word[7:0];
        merged_line = hit_line;
        merged_line[word_off*16 +: 16] = new_word;
    end

    assign line_in = reload ? mem_rdata : merged_line;
    assign cpu_rdata = old_word;

    assign victim_tag = tag_out[lru_out];
    assign victim_dirty = dirty_out[lru_out];
    assign mem_wdata = data_out[lru_out];

    always_comb begin
        if (write_back) begin
            mem_address = {victim_tag, cpu_index, {`CACHE_OFFSET_W{1'b0}}};
        end else begin
            mem_address = {cpu_tag, cpu_index, {`CACHE_OFFSET_W{1'b0}}};
        end
    end

    // A fill only ever targets a missing line, so no tag can sit in both ways
    a_one_way_match : assert property (
        @(posedge clk) disable iff (rst) !(match[0] && match[1])
    );

endmodule : cache_datapath

`default_nettype wire

// File: verilog/cache_control.sv
`timescale 1ns/1ns
`default_nettype none

module cache_control (
    input logic clk,
    input logic rst,
    input lc3b_types::cpu_req_t cpu_req,
    input logic hit,
    input logic victim_dirty,
    input logic mem_resp,
    output logic cpu_resp,
    output logic hit_enable,
    output logic reload,
    output logic write_back,
    output logic mem_read,
    output logic mem_write
);

    lc3b_types::cache_state_e state;
    lc3b_types::cache_state_e next_state;
    logic request;

    assign request = cpu_req.read | cpu_req.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lc3b_types::check;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        cpu_resp = 1'b0;
        hit_enable = 1'b0;
        reload = 1'b0;
        write_back = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;

        case (state)
            lc3b_types::check: begin
                hit_enable = request;
                cpu_resp = request & hit;               // Zero-latency hit
                if (request && !hit) begin
                    if (victim_dirty) begin
                        next_state = lc3b_types::write_back;
                    end else begin
                        next_state = lc3b_types::allocate;
                    end
                end
            end

            lc3b_types::write_back: begin
                write_back = 1'b1;                      // Victim address and data out
                mem_write = 1'b1;
                if (mem_resp) begin
                    next_state = lc3b_types::allocate;
                end
            end

            lc3b_types::allocate: begin
                mem_read = 1'b1;
                reload = mem_resp;                      // Line lands with the response
                if (mem_resp) begin
                    next_state = lc3b_types::check;
                end
            end

            default: begin
                next_state = lc3b_types::check;
            end
        endcase
    end

    // Tag and index of the request must stay put through a miss
    a_req_held : assert property (
        @(posedge clk) disable iff (rst) request && !cpu_resp |=> $stable(cpu_req)
    );

    a_resp_needs_strobe : assert property (
        @(posedge clk) disable iff (rst) mem_resp |-> (mem_read || mem_write)
    );

endmodule : cache_control

`default_nettype wire

// File: verilog/lc3b_cache.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_cache (
    input logic clk,
    input logic rst,
    input lc3b_types::cpu_req_t cpu_req,
    output logic cpu_resp,
    output lc3b_types::lc3b_word cpu_rdata,
    output lc3b_types::mem_req_t mem_req,
    input logic mem_resp,
    input lc3b_types::lc3b_c_line mem_rdata
);

    logic hit;
    logic victim_dirty;
    logic hit_enable;
    logic reload;
    logic write_back;
    logic mem_read;
    logic mem_write;
    lc3b_types::lc3b_word mem_address;
    lc3b_types::lc3b_c_line mem_wdata;

    cache_control control (
        .clk,
        .rst,
        .cpu_req,
        .hit,
        .victim_dirty,
        .mem_resp,
        .cpu_resp,
        .hit_enable,
        .reload,
        .write_back,
        .mem_read,
        .mem_write
    );

    cache_datapath datapath (
        .clk,
        .rst,
        .cpu_req,
        .hit_enable,
        .reload,
        .write_back,
        .mem_rdata,
        .hit,
        .victim_dirty,
        .cpu_rdata,
        .mem_address,
        .mem_wdata
    );

    assign mem_req = '{address: mem_address, wdata: mem_wdata,
                       read: mem_read, write: mem_write};

endmodule : lc3b_cache

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int period = 4,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;                                     // Released with the stimulus offset
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: verif/tb_lc3b_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_cache_consts.svh"

module tb_lc3b_cache;

    localparam int num_requests = 1500;
    localparam int max_cycles_per_req = 20;
    localparam int clk_period = 4;
    localparam int num_tags = 4;                        // Few tags so sets conflict often

    typedef struct packed {
        logic is_write;
        lc3b_types::lc3b_word address;
        lc3b_types::lc3b_c_line wdata;
    } mem_txn_t;

    logic clk;
    logic rst;
    lc3b_types::cpu_req_t cpu_req;
    logic cpu_resp;
    lc3b_types::lc3b_word cpu_rdata;
    lc3b_types::mem_req_t mem_req;
    logic mem_resp;
    lc3b_types::lc3b_c_line mem_rdata;

    lc3b_types::lc3b_c_line mem_lines [lc3b_types::lc3b_word];
    lc3b_types::lc3b_word exp_words [lc3b_types::lc3b_word];
    mem_txn_t mem_log [$];
    mem_txn_t exp_log [$];

    logic m_valid [`CACHE_SETS][2];
    logic m_dirty [`CACHE_SETS][2];
    lc3b_types::lc3b_c_tag m_tag [`CACHE_SETS][2];
    logic m_victim [`CACHE_SETS];                       // Way to replace next
    lc3b_types::lc3b_c_tag tag_pool [num_tags];

    int errors = 0;
    int checks = 0;
    int misses = 0;
    int write_backs = 0;

    tb_clock_gen clock_gen (
        .clk,
        .rst
    );

    lc3b_cache lc3b_cache_inst (
        .clk,
        .rst,
        .cpu_req,
        .cpu_resp,
        .cpu_rdata,
        .mem_req,
        .mem_resp,
        .mem_rdata
    );

    // Odd multiplier keeps every word address distinct
    function automatic lc3b_types::lc3b_word init_word(input lc3b_types::lc3b_word addr);
        return (addr * 16'd40503) ^ 16'h3c5a;
    endfunction

    function automatic lc3b_types::lc3b_c_line init_line(input lc3b_types::lc3b_word line_addr);
        lc3b_types::lc3b_c_line line;
        for (int i = 0; i < `CACHE_WORDS; i++) begin
            line[i*16 +: 16] = init_word(line_addr + 16'(2 * i));
        end
        return line;
    endfunction

    function automatic lc3b_types::lc3b_word expected_word(input lc3b_types::lc3b_word addr);
        return exp_words.exists(addr) ? exp_words[addr] : init_word(addr);
    endfunction

    function automatic lc3b_types::lc3b_c_line model_line(input lc3b_types::lc3b_word line_addr);
        lc3b_types::lc3b_c_line line;
        for (int i = 0; i < `CACHE_WORDS; i++) begin
            line[i*16 +: 16] = expected_word(line_addr + 16'(2 * i));
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic idle_cycle();
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;
        @(negedge clk);
        check_value("idle cpu_resp", 0, cpu_resp);
        check_value("idle mem strobes", 0, {mem_req.read, mem_req.write});
        @(posedge clk);
        #1;
    endtask

    task automatic run_request(input int n);
        lc3b_types::cpu_req_t req;
        lc3b_types::lc3b_c_tag tag;
        lc3b_types::lc3b_word line_addr;
        lc3b_types::lc3b_word old_word;
        lc3b_types::lc3b_word new_word;
        lc3b_types::lc3b_word rdata;
        mem_txn_t txn;
        logic [2:0] idx;
        logic was_hit;
        int way;
        int waited;
        string name;

        tag = tag_pool[$urandom % num_tags];
        idx = 3'($urandom);
        req.address = {tag, idx, 3'($urandom), 1'b0};
        req.wdata = 16'($urandom);
        req.byte_en = 2'(1 + $urandom % 3);
        req.write = 1'($urandom % 2);
        req.read = !req.write;
        line_addr = {tag, idx, 4'h0};
        name = $sformatf("req %0d", n);

        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                way = w;
            end
        end
        was_hit = (way >= 0);

        exp_log.delete();
        if (!was_hit) begin
            misses++;
            way = m_victim[idx];
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                write_backs++;
                txn.is_write = 1'b1;
                txn.address = {m_tag[idx][way], idx, 4'h0};
                txn.wdata = model_line(txn.address);
                exp_log.push_back(txn);
            end
            txn = '{is_write: 1'b0, address: line_addr, wdata: '0};
            exp_log.push_back(txn);
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way] = tag;
            m_dirty[idx][way] = 1'b0;
        end

        mem_log.delete();
        waited = 0;
        cpu_req = req;
        @(negedge clk);
        while (!cpu_resp) begin
            waited++;
            @(negedge clk);
        end
        rdata = cpu_rdata;
        @(posedge clk);
        #1;

        if (was_hit) begin
            check_value({name, " hit latency"}, 0, waited);
        end else begin
            check_value({name, " miss waits for memory"}, 1, waited > 0);
        end
        check_value({name, " mem txn count"}, exp_log.size(), mem_log.size());
        for (int i = 0; i < exp_log.size() && i < mem_log.size(); i++) begin
            check_value({name, " mem txn kind"}, exp_log[i].is_write, mem_log[i].is_write);
            check_value({name, " mem txn address"}, exp_log[i].address, mem_log[i].address);
            if (exp_log[i].is_write) begin
                check_value({name, " write-back data"}, exp_log[i].wdata, mem_log[i].wdata);
            end
        end

        old_word = expected_word(req.address);
        if (req.read) begin
            check_value({name, " read data"}, old_word, rdata);
        end else begin
            new_word[15:8] = req.byte_en[1] ? req.wdata[15:8] : old_word[15:8];
            new_word[7:0] = req.byte_en[0] ? req.wdata[7:0] : old_word[7:0];
            exp_words[req.address] = new_word;
            m_dirty[idx][way] = 1'b1;
        end
        m_victim[idx] = (way == 0);                     // Other way becomes the victim
    endtask

    // Samples the strobes mid-cycle and answers after a random latency
    initial begin : memory_model
        mem_txn_t txn;
        int latency;
        mem_resp = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (mem_req.read || mem_req.write)) begin
                txn.is_write = mem_req.write;
                txn.address = mem_req.address;
                txn.wdata = mem_req.write ? mem_req.wdata : '0;
                mem_log.push_back(txn);
                latency = 1 + $urandom % 8;
                repeat (latency) @(posedge clk);
                #1;
                if (txn.is_write) begin
                    mem_lines[txn.address] = txn.wdata;
                end else if (mem_lines.exists(txn.address)) begin
                    mem_rdata = mem_lines[txn.address];
                end else begin
                    mem_rdata = init_line(txn.address);
                end
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'hc1b657fb));
        cpu_req = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_victim[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        for (int i = 0; i < num_tags; i++) begin
            tag_pool[i] = {7'($urandom), 2'(i)};
        end

        wait (rst === 1'b0);
        repeat (8) begin
            @(negedge clk);
            check_value("reset idle cpu_resp", 0, cpu_resp);
            check_value("reset idle mem strobes", 0, {mem_req.read, mem_req.write});
        end
        @(posedge clk);
        #1;

        for (int n = 0; n < num_requests; n++) begin
            if ($urandom % 8 == 0) begin
                idle_cycle();
            end
            run_request(n);
        end
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;

        $display("Summary: %0d requests, %0d misses, %0d write-backs, %0d checks, %0d errors",
                 num_requests, misses, write_backs, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #((num_requests * max_cycles_per_req + 64) * clk_period);
        $display("Timeout: the run did not complete within %0d ns",
                 (num_requests * max_cycles_per_req + 64) * clk_period);
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_lc3b_cache

`default_nettype wire

// File: lc3b_cache.f
+incdir+include
verilog/lc3b_types.sv
verilog/cache_array.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/lc3b_cache.sv
verif/tb_clock_gen.sv
verif/tb_lc3b_cache.sv
